//--- verilog/rv32i_types.sv
package rv32i_types;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_REG = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // encoded as {funct7[5], funct3} of the register form
    typedef enum logic [3:0] {
        ADD = 4'b0000,
        SUB = 4'b1000,
        SLL = 4'b0001,
        SLT = 4'b0010,
        XOR = 4'b0100,
        SRL = 4'b0101,
        OR  = 4'b0110,
        AND = 4'b0111
    } alu_op_e;

    // decoded instruction as held in the issue queue
    typedef struct packed {
        opcode_e     op;
        alu_op_e     alu_op;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [2:0]  rd;
        // sign-extended I or S immediate
        logic [31:0] imm;
        logic        use_imm;
    } ctl_word;

endpackage

//--- verilog/issue_cfg.sv
package issue_cfg;

    localparam int TAG_W       = 3;
    localparam int NUM_REGS    = 8;
    localparam int IQ_DEPTH    = 4;
    localparam int NUM_RS      = 4;
    // cycles from station load to result ready
    localparam int EXEC_CYCLES = 2;

    // operands and destination handed to an ALU station
    typedef struct packed {
        rv32i_types::alu_op_e alu_op;
        logic [31:0]          src1_data;
        // register value or immediate
        logic [31:0]          src2_data;
        logic [TAG_W-1:0]     rd;
    } alu_res_word;

endpackage

//--- verilog/issue_bus_if.sv
interface issue_bus_if;

    // one-hot station select, at most one bit per cycle
    logic [issue_cfg::NUM_RS-1:0] load;
    issue_cfg::alu_res_word       word;
    // station occupancy, seen by the queue for target selection
    logic [issue_cfg::NUM_RS-1:0] busy;

    modport dispatch (
        output load,
        output word,
        input  busy
    );

    modport station (
        input  load,
        input  word,
        output busy
    );

endinterface

//--- verilog/instr_decode.sv
module instr_decode (
    input  logic [31:0]          instr_i,
    output rv32i_types::ctl_word ctl_o,
    output logic                 legal_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd_f;
    logic [4:0]  rs1_f;
    logic [4:0]  rs2_f;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic        op_ok;
    logic        funct_ok;
    logic        regs_ok;

    assign opcode = instr_i[6:0];
    assign rd_f   = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1_f  = instr_i[19:15];
    assign rs2_f  = instr_i[24:20];
    assign funct7 = instr_i[31:25];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    always_comb begin
        ctl_o        = '0;
        ctl_o.op     = rv32i_types::opcode_e'(opcode);
        ctl_o.alu_op = rv32i_types::ADD;
        ctl_o.rs1    = rs1_f[2:0];
        ctl_o.rs2    = rs2_f[2:0];
        ctl_o.rd     = rd_f[2:0];
        op_ok        = 1'b1;
        funct_ok     = 1'b1;
        // rs1 is read by every supported format
        regs_ok      = (rs1_f[4:3] == 2'b00);
        case (opcode)
            rv32i_types::OP_REG: begin
                ctl_o.alu_op = rv32i_types::alu_op_e'({funct7[5], funct3});
                // sltu has no slot, and only sub uses the alternate funct7
                funct_ok = ((funct7 == 7'b0000000) && (funct3 != 3'b011)) ||
                           ((funct7 == 7'b0100000) && (funct3 == 3'b000));
                regs_ok  = regs_ok && (rd_f[4:3] == 2'b00) && (rs2_f[4:3] == 2'b00);
            end
            rv32i_types::OP_IMM: begin
                ctl_o.alu_op  = rv32i_types::alu_op_e'({1'b0, funct3});
                ctl_o.imm     = i_imm;
                ctl_o.use_imm = 1'b1;
                // slli and srli need a zero upper field, srai is unsupported
                funct_ok = (funct3 != 3'b011) &&
                           ((funct3[1:0] != 2'b01) || (funct7 == 7'b0000000));
                regs_ok  = regs_ok && (rd_f[4:3] == 2'b00);
            end
            rv32i_types::LOAD: begin
                ctl_o.imm     = i_imm;
                ctl_o.use_imm = 1'b1;
                regs_ok       = regs_ok && (rd_f[4:3] == 2'b00);
            end
            rv32i_types::STORE: begin
                ctl_o.imm     = s_imm;
                ctl_o.use_imm = 1'b1;
                regs_ok       = regs_ok && (rs2_f[4:3] == 2'b00);
            end
            default: op_ok = 1'b0;
        endcase
    end

    assign legal_o = op_ok && funct_ok && regs_ok;

endmodule

//--- verilog/issue_fifo.sv
module issue_fifo (
    input  logic                 clk,
    input  logic                 reset_i,
    input  rv32i_types::ctl_word data_i,
    input  logic                 valid_i,
    output logic                 full_o,
    output logic                 valid_o,
    output rv32i_types::ctl_word data_o,
    input  logic                 yumi_i
);

    typedef logic [$clog2(issue_cfg::IQ_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(issue_cfg::IQ_DEPTH+1)-1:0] cnt_t;

    rv32i_types::ctl_word mem [issue_cfg::IQ_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic wr_en;
    logic rd_en;

    assign full_o  = (count == cnt_t'(issue_cfg::IQ_DEPTH));
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    // a full queue still takes a write when the head leaves in the same cycle
    assign wr_en = valid_i && (!full_o || yumi_i);
    assign rd_en = yumi_i && valid_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- verilog/reg_file.sv
module reg_file (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        we_i,
    input  logic [issue_cfg::TAG_W-1:0] waddr_i,
    input  logic [31:0]                 wdata_i,
    input  logic [issue_cfg::TAG_W-1:0] raddr1_i,
    input  logic [issue_cfg::TAG_W-1:0] raddr2_i,
    output logic [31:0]                 rdata1_o,
    output logic [31:0]                 rdata2_o
);

    logic [31:0] regs [issue_cfg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < issue_cfg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // x0 is hardwired, writes to it are dropped
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, same cycle as the tag
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- verilog/issue_queue.sv
module issue_queue (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        instr_valid_i,
    input  logic                        instr_legal_i,
    input  rv32i_types::ctl_word        ctl_i,
    output logic                        iq_full_o,
    input  logic                        rob_full_i,
    input  logic                        ldst_busy_i,
    output logic [issue_cfg::TAG_W-1:0] rf_tag1_o,
    output logic [issue_cfg::TAG_W-1:0] rf_tag2_o,
    input  logic [31:0]                 rf_data1_i,
    input  logic [31:0]                 rf_data2_i,
    issue_bus_if.dispatch               rs,
    output logic                        rob_load_o,
    output logic                        ldst_load_o,
    output logic [31:0]                 ldst_addr_o,
    output logic [31:0]                 ldst_data_o
);

    rv32i_types::ctl_word head;
    logic                 head_valid;
    logic                 enqueue;
    logic                 dequeue;
    logic                 is_ldst;
    logic                 station_free;

    // illegal words and strobes against a full queue are dropped
    assign enqueue = instr_valid_i && instr_legal_i && !iq_full_o;

    issue_fifo u_fifo (
        .clk     (clk),
        .reset_i (reset_i),
        .data_i  (ctl_i),
        .valid_i (enqueue),
        .full_o  (iq_full_o),
        .valid_o (head_valid),
        .data_o  (head),
        .yumi_i  (dequeue)
    );

    // operands for the head are read in the cycle it dispatches
    assign rf_tag1_o = head.rs1;
    assign rf_tag2_o = head.rs2;

    assign is_ldst      = (head.op == rv32i_types::LOAD) || (head.op == rv32i_types::STORE);
    assign station_free = !(&rs.busy);

    assign ldst_addr_o = rf_data1_i + head.imm;
    assign ldst_data_o = rf_data2_i;

    assign rs.word = '{
        alu_op:    head.alu_op,
        src1_data: rf_data1_i,
        src2_data: head.use_imm ? head.imm : rf_data2_i,
        rd:        head.rd
    };

    always_comb begin
        rs.load     = '0;
        ldst_load_o = 1'b0;
        dequeue     = 1'b0;
        if (head_valid && !rob_full_i) begin
            if (is_ldst) begin
                if (!ldst_busy_i) begin
                    ldst_load_o = 1'b1;
                    dequeue     = 1'b1;
                end
            end else if (station_free) begin
                dequeue = 1'b1;
                // scan downward so the lowest free station is the last one kept
                for (int i = issue_cfg::NUM_RS - 1; i >= 0; i--) begin
                    if (!rs.busy[i]) begin
                        rs.load    = '0;
                        rs.load[i] = 1'b1;
                    end
                end
            end
        end
    end

    // every dispatch takes a reorder buffer slot
    assign rob_load_o = dequeue;

endmodule

//--- verilog/alu_stations.sv
module alu_stations (
    input  logic                        clk,
    input  logic                        reset_i,
    issue_bus_if.station                rs,
    output logic                        result_valid_o,
    output logic [issue_cfg::TAG_W-1:0] result_rd_o,
    output logic [31:0]                 result_data_o
);

    typedef enum logic [1:0] {
        FREE,
        EXEC,
        DONE
    } st_e;

    typedef logic [$clog2(issue_cfg::EXEC_CYCLES+1)-1:0] cnt_t;

    st_e                    state    [issue_cfg::NUM_RS];
    cnt_t                   cnt      [issue_cfg::NUM_RS];
    issue_cfg::alu_res_word word_q   [issue_cfg::NUM_RS];
    logic [31:0]            result_q [issue_cfg::NUM_RS];
    logic [issue_cfg::NUM_RS-1:0] grant;

    function automatic logic [31:0] alu_calc(issue_cfg::alu_res_word w);
        case (w.alu_op)
            rv32i_types::ADD: return w.src1_data + w.src2_data;
            rv32i_types::SUB: return w.src1_data - w.src2_data;
            rv32i_types::SLL: return w.src1_data << w.src2_data[4:0];
            rv32i_types::SLT: return {31'b0, $signed(w.src1_data) < $signed(w.src2_data)};
            rv32i_types::XOR: return w.src1_data ^ w.src2_data;
            rv32i_types::SRL: return w.src1_data >> w.src2_data[4:0];
            rv32i_types::OR:  return w.src1_data | w.src2_data;
            rv32i_types::AND: return w.src1_data & w.src2_data;
            default:          return '0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < issue_cfg::NUM_RS; i++) begin
            rs.busy[i] = (state[i] != FREE);
        end
    end

    // fixed priority, station 0 wins
    always_comb begin
        grant = '0;
        for (int i = issue_cfg::NUM_RS - 1; i >= 0; i--) begin
            if (state[i] == DONE) begin
                grant    = '0;
                grant[i] = 1'b1;
            end
        end
    end

    always_comb begin
        result_valid_o = |grant;
        result_rd_o    = '0;
        result_data_o  = '0;
        for (int i = 0; i < issue_cfg::NUM_RS; i++) begin
            if (grant[i]) begin
                result_rd_o   = word_q[i].rd;
                result_data_o = result_q[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_cfg::NUM_RS; i++) begin
            if (reset_i) begin
                state[i] <= FREE;
                cnt[i]   <= '0;
            end else begin
                case (state[i])
                    FREE: begin
                        if (rs.load[i]) begin
                            state[i] <= EXEC;
                            cnt[i]   <= cnt_t'(issue_cfg::EXEC_CYCLES - 1);
                        end
                    end
                    EXEC: begin
                        if (cnt[i] == '0) begin
                            state[i] <= DONE;
                        end else begin
                            cnt[i] <= cnt[i] - 1'b1;
                        end
                    end
                    // a losing station keeps its result until granted
                    DONE: begin
                        if (grant[i]) begin
                            state[i] <= FREE;
                        end
                    end
                    default: state[i] <= FREE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_cfg::NUM_RS; i++) begin
            if ((state[i] == FREE) && rs.load[i]) begin
                word_q[i] <= rs.word;
            end
            if ((state[i] == EXEC) && (cnt[i] == '0)) begin
                result_q[i] <= alu_calc(word_q[i]);
            end
        end
    end

endmodule

//--- verilog/issue_top.sv
module issue_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        instr_valid_i,
    input  logic [31:0]                 instr_i,
    output logic                        iq_full_o,
    output logic                        illegal_o,
    input  logic                        rob_full_i,
    input  logic                        ldst_busy_i,
    input  logic                        reg_we_i,
    input  logic [issue_cfg::TAG_W-1:0] reg_waddr_i,
    input  logic [31:0]                 reg_wdata_i,
    output logic                        rob_load_o,
    output logic                        ldst_load_o,
    output logic [31:0]                 ldst_addr_o,
    output logic [31:0]                 ldst_data_o,
    output logic                        result_valid_o,
    output logic [issue_cfg::TAG_W-1:0] result_rd_o,
    output logic [31:0]                 result_data_o
);

    rv32i_types::ctl_word        ctl;
    logic                        legal;
    logic [issue_cfg::TAG_W-1:0] rf_tag1;
    logic [issue_cfg::TAG_W-1:0] rf_tag2;
    logic [31:0]                 rf_data1;
    logic [31:0]                 rf_data2;

    issue_bus_if rs_bus ();

    instr_decode u_decode (
        .instr_i (instr_i),
        .ctl_o   (ctl),
        .legal_o (legal)
    );

    // flagged on the strobe itself, even if the queue is full
    assign illegal_o = instr_valid_i && !legal;

    issue_queue u_queue (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_legal_i (legal),
        .ctl_i         (ctl),
        .iq_full_o     (iq_full_o),
        .rob_full_i    (rob_full_i),
        .ldst_busy_i   (ldst_busy_i),
        .rf_tag1_o     (rf_tag1),
        .rf_tag2_o     (rf_tag2),
        .rf_data1_i    (rf_data1),
        .rf_data2_i    (rf_data2),
        .rs            (rs_bus.dispatch),
        .rob_load_o    (rob_load_o),
        .ldst_load_o   (ldst_load_o),
        .ldst_addr_o   (ldst_addr_o),
        .ldst_data_o   (ldst_data_o)
    );

    reg_file u_regs (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (reg_we_i),
        .waddr_i  (reg_waddr_i),
        .wdata_i  (reg_wdata_i),
        .raddr1_i (rf_tag1),
        .raddr2_i (rf_tag2),
        .rdata1_o (rf_data1),
        .rdata2_o (rf_data2)
    );

    alu_stations u_stations (
        .clk            (clk),
        .reset_i        (reset_i),
        .rs             (rs_bus.station),
        .result_valid_o (result_valid_o),
        .result_rd_o    (result_rd_o),
        .result_data_o  (result_data_o)
    );

endmodule

//--- sim/issue_checker.sv
module issue_checker (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        result_valid_i,
    input logic [issue_cfg::TAG_W-1:0] result_rd_i,
    input logic [31:0]                 result_data_i,
    input logic                        rob_load_i,
    input logic                        ldst_load_i,
    input logic [31:0]                 ldst_addr_i,
    input logic [31:0]                 ldst_data_i
);

    // ALU results may return in any order
    logic [issue_cfg::TAG_W-1:0] alu_rd_q   [$];
    logic [31:0]                 alu_data_q [$];
    // loads and stores leave in program order
    logic [31:0]                 ls_addr_q  [$];
    logic [31:0]                 ls_data_q  [$];
    logic                        ls_dchk_q  [$];

    int errors       = 0;
    int accepted     = 0;
    int rob_count    = 0;
    int result_count = 0;
    int ldst_count   = 0;

    task automatic expect_alu(input logic [issue_cfg::TAG_W-1:0] rd, input logic [31:0] data);
        alu_rd_q.push_back(rd);
        alu_data_q.push_back(data);
        accepted++;
    endtask

    // data is only meaningful for stores
    task automatic expect_ldst(input logic [31:0] addr, input logic [31:0] data,
                               input logic dchk);
        ls_addr_q.push_back(addr);
        ls_data_q.push_back(data);
        ls_dchk_q.push_back(dchk);
        accepted++;
    endtask

    function automatic bit drained();
        return (alu_rd_q.size() == 0) && (ls_addr_q.size() == 0);
    endfunction

    function automatic int rob_mismatch();
        if (rob_count != accepted) begin
            $display("rob_load_o pulsed %0d times for %0d accepted instructions",
                     rob_count, accepted);
            return 1;
        end
        return 0;
    endfunction

    task automatic match_result();
        int hit;
        int near;
        hit  = -1;
        near = 0;
        for (int i = 0; i < alu_rd_q.size(); i++) begin
            if (alu_rd_q[i] == result_rd_i) begin
                near = i;
                if ((hit < 0) && (alu_data_q[i] == result_data_i)) begin
                    hit = i;
                end
            end
        end
        if (hit >= 0) begin
            alu_rd_q.delete(hit);
            alu_data_q.delete(hit);
        end else if (alu_rd_q.size() == 0) begin
            $display("unexpected result for x%0d with no ALU instruction outstanding",
                     result_rd_i);
            errors++;
        end else begin
            $display("Error at time %0t: result_data_o expected %h actual %h (x%0d)",
                     $time, alu_data_q[near], result_data_i, result_rd_i);
            errors++;
        end
    endtask

    task automatic match_ldst();
        if (ls_addr_q.size() == 0) begin
            $display("ldst_load_o pulsed with no load or store outstanding");
            errors++;
        end else begin
            if (ldst_addr_i !== ls_addr_q[0]) begin
                $display("Error at time %0t: ldst_addr_o expected %h actual %h",
                         $time, ls_addr_q[0], ldst_addr_i);
                errors++;
            end
            if (ls_dchk_q[0] && (ldst_data_i !== ls_data_q[0])) begin
                $display("Error at time %0t: ldst_data_o expected %h actual %h",
                         $time, ls_data_q[0], ldst_data_i);
                errors++;
            end
            void'(ls_addr_q.pop_front());
            void'(ls_data_q.pop_front());
            void'(ls_dchk_q.pop_front());
        end
    endtask

    // outputs are sampled at the rising edge, inputs settle at the falling edge
    initial begin
        forever begin
            @(posedge clk);
            if (!reset_i) begin
                if (rob_load_i) begin
                    rob_count++;
                end
                if (result_valid_i) begin
                    result_count++;
                    match_result();
                end
                if (ldst_load_i) begin
                    ldst_count++;
                    match_ldst();
                end
            end
        end
    end

endmodule

//--- sim/issue_tb.sv
module issue_tb;

    localparam int TIMEOUT = 200;

    logic                        clk;
    logic                        reset_i;
    logic                        instr_valid_i;
    logic [31:0]                 instr_i;
    logic                        iq_full_o;
    logic                        illegal_o;
    logic                        rob_full_i;
    logic                        ldst_busy_i;
    logic                        reg_we_i;
    logic [issue_cfg::TAG_W-1:0] reg_waddr_i;
    logic [31:0]                 reg_wdata_i;
    logic                        rob_load_o;
    logic                        ldst_load_o;
    logic [31:0]                 ldst_addr_o;
    logic [31:0]                 ldst_data_o;
    logic                        result_valid_o;
    logic [issue_cfg::TAG_W-1:0] result_rd_o;
    logic [31:0]                 result_data_o;

    // no writeback, so the shadow copy stays as preloaded
    logic [31:0] shadow [issue_cfg::NUM_REGS];
    logic [31:0] r;
    int seed      = 96232;
    int tb_errors = 0;
    int err_mark  = 0;

    rv32i_types::alu_op_e ops [8] = '{rv32i_types::ADD, rv32i_types::SUB, rv32i_types::SLL,
                                      rv32i_types::SLT, rv32i_types::XOR, rv32i_types::SRL,
                                      rv32i_types::OR, rv32i_types::AND};

    issue_top DUT (.*);

    issue_checker chk (
        .clk            (clk),
        .reset_i        (reset_i),
        .result_valid_i (result_valid_o),
        .result_rd_i    (result_rd_o),
        .result_data_i  (result_data_o),
        .rob_load_i     (rob_load_o),
        .ldst_load_i    (ldst_load_o),
        .ldst_addr_i    (ldst_addr_o),
        .ldst_data_i    (ldst_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] alu_ref(rv32i_types::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
        case (op)
            rv32i_types::ADD: return a + b;
            rv32i_types::SUB: return a - b;
            rv32i_types::SLL: return a << b[4:0];
            rv32i_types::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv32i_types::XOR: return a ^ b;
            rv32i_types::SRL: return a >> b[4:0];
            rv32i_types::OR:  return a | b;
            rv32i_types::AND: return a & b;
            default:          return 32'd0;
        endcase
    endfunction

    // drives one strobe across a single rising edge
    task automatic send(input logic [31:0] w, input bit legal);
        int t;
        t = 0;
        while (iq_full_o && (t < TIMEOUT)) begin
            @(negedge clk);
            t++;
        end
        if (iq_full_o) begin
            $display("timeout: issue queue never left the full state");
            tb_errors++;
            return;
        end
        instr_valid_i = 1'b1;
        instr_i       = w;
        @(posedge clk);
        if (illegal_o !== !legal) begin
            $display("Error at time %0t: illegal_o expected %b actual %b",
                     $time, !legal, illegal_o);
            tb_errors++;
        end
        @(negedge clk);
        instr_valid_i = 1'b0;
    endtask

    task automatic issue_alu(input bit imm_form, input rv32i_types::alu_op_e op,
                             input logic [2:0] rd, input logic [2:0] rs1,
                             input logic [2:0] rs2, input logic [11:0] imm);
        logic [31:0] w;
        logic [31:0] b;
        logic [11:0] iv;
        if (imm_form && (op == rv32i_types::SUB)) begin
            op = rv32i_types::ADD;
        end
        // shift immediates carry only a shift amount
        iv = ((op == rv32i_types::SLL) || (op == rv32i_types::SRL)) ? {7'b0, imm[4:0]} : imm;
        if (imm_form) begin
            w = {iv, 2'b0, rs1, op[2:0], 2'b0, rd, 7'b0010011};
            b = {{20{iv[11]}}, iv};
        end else begin
            w = {1'b0, op[3], 5'b0, 2'b0, rs2, 2'b0, rs1, op[2:0], 2'b0, rd, 7'b0110011};
            b = shadow[rs2];
        end
        chk.expect_alu(rd, alu_ref(op, shadow[rs1], b));
        send(w, 1'b1);
    endtask

    task automatic issue_ldst(input bit store, input logic [2:0] rs1, input logic [2:0] reg2,
                              input logic [11:0] imm);
        logic [31:0] w;
        if (store) begin
            w = {imm[11:5], 2'b0, reg2, 2'b0, rs1, 3'b010, imm[4:0], 7'b0100011};
        end else begin
            w = {imm, 2'b0, rs1, 3'b010, 2'b0, reg2, 7'b0000011};
        end
        chk.expect_ldst(shadow[rs1] + {{20{imm[11]}}, imm}, shadow[reg2], store);
        send(w, 1'b1);
    endtask

    task automatic expect_quiet(input int cycles);
        int rob0;
        int ls0;
        int res0;
        rob0 = chk.rob_count;
        ls0  = chk.ldst_count;
        res0 = chk.result_count;
        repeat (cycles) @(negedge clk);
        if ((chk.rob_count != rob0) || (chk.ldst_count != ls0) ||
            (chk.result_count != res0)) begin
            $display("dispatch or result seen while the DUT should be stalled");
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int t;
        int total;
        t = 0;
        while (!chk.drained() && (t < TIMEOUT)) begin
            @(negedge clk);
            t++;
        end
        if (!chk.drained()) begin
            $display("timeout: %s still has expected items outstanding", name);
            tb_errors++;
        end
        tb_errors += chk.rob_mismatch();
        total = tb_errors + chk.errors;
        $display("%s: %s", name, (total == err_mark) ? "ok" : "FAIL");
        err_mark = total;
    endtask

    initial begin
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rob_full_i    = 1'b0;
        ldst_busy_i   = 1'b0;
        reg_we_i      = 1'b0;
        reg_waddr_i   = '0;
        reg_wdata_i   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i   = 1'b0;
        shadow[0] = '0;
        for (int i = 1; i < issue_cfg::NUM_REGS; i++) begin
            shadow[i]   = $random(seed);
            reg_we_i    = 1'b1;
            reg_waddr_i = 3'(i);
            reg_wdata_i = shadow[i];
            @(negedge clk);
        end
        reg_we_i = 1'b0;

        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            issue_alu(r[3], ops[r[2:0]], r[6:4], r[9:7], r[12:10], r[24:13]);
        end
        finish_test("test 1 random alu");

        ldst_busy_i = 1'b1;
        issue_ldst(1'b1, 3'd1, 3'd2, 12'h010);
        issue_ldst(1'b0, 3'd3, 3'd4, 12'hff8);
        issue_ldst(1'b1, 3'd5, 3'd6, 12'h7fc);
        expect_quiet(8);
        ldst_busy_i = 1'b0;
        finish_test("test 2 load store order");

        rob_full_i = 1'b1;
        // a store at the head must also wait for a reorder buffer slot
        issue_ldst(1'b1, 3'd7, 3'd1, 12'h024);
        for (int n = 0; n < issue_cfg::IQ_DEPTH - 1; n++) begin
            issue_alu(n[0], ops[n + 1], 3'(n + 1), 3'(n + 2), 3'(n + 3), 12'(240 + n));
        end
        if (!iq_full_o) begin
            $display("Error at time %0t: iq_full_o expected 1 actual %b", $time, iq_full_o);
            tb_errors++;
        end
        expect_quiet(8);
        rob_full_i = 1'b0;
        finish_test("test 3 rob full stall");

        for (int n = 0; n < 8; n++) begin
            issue_alu(1'b0, ops[n], 3'(n), 3'(7 - n), 3'(n + 1), 12'h000);
        end
        finish_test("test 4 alu burst");

        // unknown custom-0 opcode and an add that writes x9
        send(32'h0000000b, 1'b0);
        send({7'b0, 5'd2, 5'd1, 3'b000, 5'd9, 7'b0110011}, 1'b0);
        issue_alu(1'b0, rv32i_types::ADD, 3'd4, 3'd5, 3'd6, 12'h000);
        finish_test("test 5 illegal encodings");

        $display("summary: %0d results, %0d loads/stores, %0d rob loads, %0d errors",
                 chk.result_count, chk.ldst_count, chk.rob_count, tb_errors + chk.errors);
        if ((tb_errors + chk.errors) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/rv32i_types.sv
verilog/issue_cfg.sv
verilog/issue_bus_if.sv
verilog/instr_decode.sv
verilog/issue_fifo.sv
verilog/reg_file.sv
verilog/issue_queue.sv
verilog/alu_stations.sv
verilog/issue_top.sv
sim/issue_checker.sv
sim/issue_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f verilog.f --top-module issue_tb -o issue_sim
./obj_dir/issue_sim > sim.log
cat sim.log
if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
